/* common/simd_config.svh */
// Sizing macros for the SIMD lane core.
// SIMD_NUM_LANES must be a power of two. The lane index and the SUM
// walk counter are sized from it.
// SIMD_NUM_STAGES must be a power of two as well, so that the stage
// index wraps cleanly.

`ifndef SIMD_CONFIG_SVH
`define SIMD_CONFIG_SVH

// ------------------------------------------------------------
// lane geometry
// ------------------------------------------------------------
`define SIMD_NUM_LANES 8     // execution lanes per processing element
`define SIMD_LANE_WIDTH 32   // signed two's complement lane data

// ------------------------------------------------------------
// program length
// ------------------------------------------------------------
`define SIMD_NUM_STAGES 4    // wrapper op slots per program

`endif

/* common/simd_pkg.sv */
// Shared types for the SIMD lane core.
// Lane data is signed, and all arithmetic on it wraps modulo 2^32.
// lane_set_t is the only carrier of a full set of lanes between blocks.

`include "simd_config.svh"

package simd_pkg;

  // ------------------------------------------------------------
  // lane level types
  // ------------------------------------------------------------
  typedef logic signed [`SIMD_LANE_WIDTH-1:0] lane_data_t;
  typedef logic [$clog2(`SIMD_NUM_LANES)-1:0] lane_idx_t;
  typedef logic [`SIMD_NUM_LANES-1:0] lane_mask_t;

  // wrapper operation codes, one per program stage
  typedef enum logic [1:0] {
    NOP      = 2'd0,  // ends the program
    SUM_SAVE = 2'd1,
    RELU     = 2'd2
  } wrap_op_e;

  // full set of lanes, valid mask on top
  typedef struct packed {
    lane_mask_t                             valid;
    lane_data_t [`SIMD_NUM_LANES-1:0]       data;
  } lane_set_t;

  // program, stage 0 sits in ops[0]
  typedef struct packed {
    wrap_op_e [`SIMD_NUM_STAGES-1:0] ops;
    lane_idx_t                       sum_lane;  // SUM_SAVE target
  } simd_cfg_t;

  // ------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE, PREPARE, SFU_START, SFU_RUN, SFU_DONE, FINISH
  } ctrl_state_e;

  typedef enum logic [1:0] {
    WAIT, ADD_ALL, COMPLETE
  } sum_state_e;

endpackage

/* sfu/sfu_sum.sv */
// Sequential adder over the valid lanes.
// It walks lanes 0 to SIMD_NUM_LANES-1, one per cycle, and then pulses done
// with the total. done is also the write strobe to the lane store.
// Start to done takes SIMD_NUM_LANES+1 cycles. The sum wraps modulo 2^32.
// work_lanes must stay stable during the walk, and a start outside WAIT
// is ignored.

`timescale 1ns/1ns

`include "simd_config.svh"

module sfu_sum (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  simd_pkg::lane_set_t  work_lanes,
  output logic                 done,
  output simd_pkg::lane_data_t total
);

  localparam int CNT_W = $clog2(`SIMD_NUM_LANES) + 1;  // one spare bit to reach the count

  simd_pkg::sum_state_e state;
  simd_pkg::sum_state_e state_nxt;
  logic [CNT_W-1:0]     cnt;
  logic [CNT_W-1:0]     cnt_inc;
  simd_pkg::lane_idx_t  idx;
  simd_pkg::lane_data_t addend;
  simd_pkg::lane_data_t acc;

  assign cnt_inc = cnt + 1'b1;
  assign idx     = cnt[CNT_W-2:0];
  assign addend  = work_lanes.valid[idx] ? work_lanes.data[idx] : '0;  // skip invalid lanes

  // ------------------------------------------------------------
  // walk control
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      simd_pkg::WAIT:
        if (start)
          state_nxt = simd_pkg::ADD_ALL;
      simd_pkg::ADD_ALL:
        if (cnt_inc == CNT_W'(`SIMD_NUM_LANES))
          state_nxt = simd_pkg::COMPLETE;
      simd_pkg::COMPLETE:
        state_nxt = simd_pkg::WAIT;
      default:
        state_nxt = simd_pkg::WAIT;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= simd_pkg::WAIT;
      cnt   <= '0;
    end
    else
    begin
      state <= state_nxt;
      if ((state == simd_pkg::WAIT) && start)
        cnt <= '0;
      else if (state == simd_pkg::ADD_ALL)
        cnt <= cnt_inc;
    end
  end

  // ------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if ((state == simd_pkg::WAIT) && start)
      acc <= '0;
    else if (state == simd_pkg::ADD_ALL)
      acc <= acc + addend;
  end

  assign done  = (state == simd_pkg::COMPLETE);
  assign total = acc;

endmodule

/* sfu/sfu_relu.sv */
// RELU unit. It clamps the negative values of the valid lanes to zero.
// Invalid lanes pass through untouched, and the valid bits are kept.
// result and done come one cycle after start, and done is also the write strobe.

`timescale 1ns/1ns

`include "simd_config.svh"

module sfu_relu (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  simd_pkg::lane_set_t work_lanes,
  output logic                done,
  output simd_pkg::lane_set_t result
);

  simd_pkg::lane_set_t clamped;

  always_comb
  begin
    clamped.valid = work_lanes.valid;
    for (int i = 0; i < `SIMD_NUM_LANES; i++)
    begin
      // sign bit set on a valid lane, force to zero
      if (work_lanes.valid[i] && work_lanes.data[i][`SIMD_LANE_WIDTH-1])
        clamped.data[i] = '0;
      else
        clamped.data[i] = work_lanes.data[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      done <= 1'b0;
    else
      done <= start;  // single-cycle unit
  end

  always_ff @(posedge clk)
  begin
    if (start)
      result <= clamped;
  end

endmodule

/* rtl/lane_regs.sv */
// Lane store of the SIMD lane core.
// Working lanes follow in_lanes while capture is high and take unit
// results afterwards. The SUM and RELU strobes never come in the same cycle.
// out_lanes changes only on finish. Only its valid bits are reset.

`timescale 1ns/1ns

`include "simd_config.svh"

module lane_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 capture,
  input  logic                 finish,
  input  simd_pkg::lane_set_t  in_lanes,
  output simd_pkg::lane_set_t  work_lanes,
  input  logic                 sum_wr,
  input  simd_pkg::lane_idx_t  sum_lane,
  input  simd_pkg::lane_data_t sum_value,
  input  logic                 relu_wr,
  input  simd_pkg::lane_set_t  relu_lanes,
  output simd_pkg::lane_set_t  out_lanes
);

  simd_pkg::lane_mask_t                        out_valid;
  simd_pkg::lane_data_t [`SIMD_NUM_LANES-1:0]  out_data;

  // ------------------------------------------------------------
  // working lanes
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (capture)
      work_lanes <= in_lanes;
    else if (sum_wr)
    begin
      work_lanes.data[sum_lane]  <= sum_value;
      work_lanes.valid[sum_lane] <= 1'b1;  // target lane becomes valid
    end
    else if (relu_wr)
      work_lanes <= relu_lanes;  // whole set, valid bits unchanged by relu
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= '0;
    else if (finish)
      out_valid <= work_lanes.valid;
  end

  always_ff @(posedge clk)
  begin
    if (finish)
      out_data <= work_lanes.data;
  end

  assign out_lanes = '{valid: out_valid, data: out_data};

endmodule

/* rtl/simd_ctrl.sv */
// Main controller of the SIMD lane core.
// Steps through up to SIMD_NUM_STAGES wrapper ops and stops at the first NOP.
// Only one function unit runs at a time. A NOP stage finishes in its
// start cycle without touching any unit.
// cfg_valid is dropped in the complete cycle, because processing is still
// high there.

`timescale 1ns/1ns

`include "simd_config.svh"

module simd_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_valid,
  input  simd_pkg::simd_cfg_t cfg,
  output logic                capture,
  output logic                sum_start,
  output logic                relu_start,
  output logic                finish,
  output simd_pkg::lane_idx_t sum_lane,
  input  logic                sum_done,
  input  logic                relu_done,
  output logic                processing,
  output logic                complete
);

  localparam int STAGE_W    = $clog2(`SIMD_NUM_STAGES);
  localparam int LAST_STAGE = `SIMD_NUM_STAGES - 1;

  simd_pkg::ctrl_state_e state;
  simd_pkg::ctrl_state_e state_nxt;
  simd_pkg::simd_cfg_t   cfg_q;      // program held for the whole run
  logic [STAGE_W-1:0]    stage;
  logic [STAGE_W-1:0]    stage_inc;
  simd_pkg::wrap_op_e    cur_op;
  logic                  accept;
  logic                  unit_done;
  logic                  prog_end;

  // ------------------------------------------------------------
  // stage decode
  // ------------------------------------------------------------
  assign accept    = (state == simd_pkg::IDLE) && !complete && cfg_valid;
  assign cur_op    = cfg_q.ops[stage];
  assign stage_inc = stage + 1'b1;     // wraps on the last stage, masked below

  // only the unit that was started can answer
  assign unit_done = (cur_op == simd_pkg::SUM_SAVE) ? sum_done : relu_done;

  // last slot used, or the next slot is empty
  assign prog_end = (stage == LAST_STAGE[STAGE_W-1:0])
                 || (cur_op == simd_pkg::NOP)
                 || (cfg_q.ops[stage_inc] == simd_pkg::NOP);

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      simd_pkg::IDLE:
        if (accept)
          state_nxt = simd_pkg::PREPARE;
      simd_pkg::PREPARE:
        state_nxt = simd_pkg::SFU_START;
      simd_pkg::SFU_START:
        state_nxt = (cur_op == simd_pkg::NOP) ? simd_pkg::SFU_DONE : simd_pkg::SFU_RUN;
      simd_pkg::SFU_RUN:
        if (unit_done)
          state_nxt = simd_pkg::SFU_DONE;
      simd_pkg::SFU_DONE:
        state_nxt = prog_end ? simd_pkg::FINISH : simd_pkg::SFU_START;
      simd_pkg::FINISH:
        state_nxt = simd_pkg::IDLE;
      default:
        state_nxt = simd_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= simd_pkg::IDLE;
      stage    <= '0;
      complete <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      complete <= (state == simd_pkg::FINISH);  // lines up with out_lanes update
      if (state == simd_pkg::PREPARE)
        stage <= '0;
      else if ((state == simd_pkg::SFU_DONE) && !prog_end)
        stage <= stage_inc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cfg_q <= cfg;
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign capture    = (state == simd_pkg::IDLE);
  assign sum_start  = (state == simd_pkg::SFU_START) && (cur_op == simd_pkg::SUM_SAVE);
  assign relu_start = (state == simd_pkg::SFU_START) && (cur_op == simd_pkg::RELU);
  assign finish     = (state == simd_pkg::FINISH);
  assign sum_lane   = cfg_q.sum_lane;

  // high from PREPARE through the complete cycle
  assign processing = (state != simd_pkg::IDLE) || complete;

endmodule

/* rtl/simd_core.sv */
// SIMD lane core for one processing element.
// cfg_valid is a strobe, honoured only while processing is low.
// complete is a one-cycle pulse. out_lanes holds from that cycle until
// the next completion. There is no back-pressure on the output.
// Latency depends on the program. Each SUM_SAVE stage takes 11 cycles and
// each RELU stage 3, plus 2 cycles of overhead per program.
// A leading NOP stage costs 2 cycles.

`timescale 1ns/1ns

module simd_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_valid,
  input  simd_pkg::simd_cfg_t cfg,
  input  simd_pkg::lane_set_t in_lanes,
  output logic                processing,
  output logic                complete,
  output simd_pkg::lane_set_t out_lanes
);

  // controller to lane store and units
  logic                 capture;
  logic                 finish;
  logic                 sum_start;
  logic                 relu_start;
  simd_pkg::lane_idx_t  sum_lane;

  // each unit's done also acts as its write strobe
  logic                 sum_done;
  simd_pkg::lane_data_t sum_total;
  logic                 relu_done;
  simd_pkg::lane_set_t  relu_lanes;

  simd_pkg::lane_set_t  work_lanes;

  simd_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .cfg_valid  (cfg_valid),
    .cfg        (cfg),
    .capture    (capture),
    .sum_start  (sum_start),
    .relu_start (relu_start),
    .finish     (finish),
    .sum_lane   (sum_lane),
    .sum_done   (sum_done),
    .relu_done  (relu_done),
    .processing (processing),
    .complete   (complete)
  );

  lane_regs u_lane_regs (
    .clk        (clk),
    .rst        (rst),
    .capture    (capture),
    .finish     (finish),
    .in_lanes   (in_lanes),
    .work_lanes (work_lanes),
    .sum_wr     (sum_done),
    .sum_lane   (sum_lane),
    .sum_value  (sum_total),
    .relu_wr    (relu_done),
    .relu_lanes (relu_lanes),
    .out_lanes  (out_lanes)
  );

  sfu_sum u_sfu_sum (
    .clk        (clk),
    .rst        (rst),
    .start      (sum_start),
    .work_lanes (work_lanes),
    .done       (sum_done),
    .total      (sum_total)
  );

  sfu_relu u_sfu_relu (
    .clk        (clk),
    .rst        (rst),
    .start      (relu_start),
    .work_lanes (work_lanes),
    .done       (relu_done),
    .result     (relu_lanes)
  );

endmodule

/* verif/tb_clk_gen.sv */
// Clock and reset for the SIMD core testbench.
// 10 ns period. rst is high for the first 3 rising edges.

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_NS = 5;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;  // released after the third edge
  end

endmodule

/* verif/simd_core_tb.sv */
// Testbench for the SIMD lane core.
// Inputs change on the falling edge. Results are checked by assertions
// on the rising edge, against a model of the wrapper op rules.
// Random lanes and programs come from $random with a fixed seed.

`timescale 1ns/1ns

`include "simd_config.svh"

module simd_core_tb;

  localparam int NUM_RANDOM = 20;
  localparam int NUM_PROGS  = 6 + NUM_RANDOM;
  localparam int TIMEOUT_NS = (NUM_PROGS * 64 + 3 + 10) * 10;  // 64 cycles per program

  logic                clk;
  logic                rst;
  logic                cfg_valid;
  simd_pkg::simd_cfg_t cfg;
  simd_pkg::lane_set_t in_lanes;
  logic                processing;
  logic                complete;
  simd_pkg::lane_set_t out_lanes;

  simd_pkg::lane_set_t exp_lanes;   // model result of the running program
  simd_pkg::lane_set_t last_out;    // out_lanes seen at the last complete
  logic                seen_complete;
  integer              seed;
  int                  accepted;
  int                  complete_count;
  int                  value_errs;
  int                  proto_errs;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  simd_core u_simd_core (
    .clk        (clk),
    .rst        (rst),
    .cfg_valid  (cfg_valid),
    .cfg        (cfg),
    .in_lanes   (in_lanes),
    .processing (processing),
    .complete   (complete),
    .out_lanes  (out_lanes)
  );

  // ------------------------------------------------------------
  // reference model applied stage by stage
  // ------------------------------------------------------------
  function automatic simd_pkg::lane_set_t model_program(input simd_pkg::lane_set_t lanes,
                                                        input simd_pkg::simd_cfg_t c);
    simd_pkg::lane_set_t  r;
    simd_pkg::lane_data_t acc;
    logic                 stop;
    r    = lanes;
    stop = 1'b0;
    for (int s = 0; s < `SIMD_NUM_STAGES; s++)
    begin
      if (c.ops[s] == simd_pkg::NOP)
        stop = 1'b1;  // first NOP ends the program
      if (!stop && (c.ops[s] == simd_pkg::SUM_SAVE))
      begin
        acc = '0;
        for (int i = 0; i < `SIMD_NUM_LANES; i++)
          if (r.valid[i])
            acc = acc + r.data[i];  // wraps mod 2^32
        r.data[c.sum_lane]  = acc;
        r.valid[c.sum_lane] = 1'b1;
      end
      if (!stop && (c.ops[s] == simd_pkg::RELU))
        for (int i = 0; i < `SIMD_NUM_LANES; i++)
          if (r.valid[i] && (r.data[i] < 0))
            r.data[i] = '0;
    end
    return r;
  endfunction

  function automatic simd_pkg::simd_cfg_t make_cfg(input simd_pkg::wrap_op_e op0,
    input simd_pkg::wrap_op_e op1, input simd_pkg::wrap_op_e op2,
    input simd_pkg::wrap_op_e op3, input simd_pkg::lane_idx_t target);
    simd_pkg::simd_cfg_t c;
    c.ops[0]   = op0;
    c.ops[1]   = op1;
    c.ops[2]   = op2;
    c.ops[3]   = op3;
    c.sum_lane = target;
    return c;
  endfunction

  task automatic random_lanes(output simd_pkg::lane_set_t l);
    l.valid = simd_pkg::lane_mask_t'($random(seed));
    for (int i = 0; i < `SIMD_NUM_LANES; i++)
      l.data[i] = $random(seed);
  endtask

  task automatic random_cfg(output simd_pkg::simd_cfg_t c);
    for (int s = 0; s < `SIMD_NUM_STAGES; s++)
      c.ops[s] = simd_pkg::wrap_op_e'($unsigned($random(seed)) % 3);
    c.sum_lane = simd_pkg::lane_idx_t'($random(seed));
  endtask

  // one program from strobe to complete with an optional stray strobe
  task automatic run_program(input simd_pkg::simd_cfg_t c, input simd_pkg::lane_set_t lanes,
                             input logic stray);
    simd_pkg::simd_cfg_t junk_cfg;
    simd_pkg::lane_set_t junk_lanes;
    cfg       = c;
    in_lanes  = lanes;
    cfg_valid = 1'b1;
    exp_lanes = model_program(lanes, c);
    accepted++;
    @(negedge clk);
    cfg_valid = 1'b0;
    if (stray)
    begin
      random_cfg(junk_cfg);
      random_lanes(junk_lanes);
      @(negedge clk);
      cfg       = junk_cfg;
      in_lanes  = junk_lanes;
      cfg_valid = 1'b1;  // processing is high here
      @(negedge clk);
      cfg_valid = 1'b0;
    end
    while (!complete)
      @(negedge clk);
    @(negedge clk);  // let the complete cycle be checked
  endtask

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  always @(negedge clk)
  begin
    if (!rst && complete)
    begin
      complete_count++;
      seen_complete = 1'b1;
      last_out      = out_lanes;
    end
  end

  out_value_check: assert property (@(posedge clk) disable iff (rst)
    complete |-> (out_lanes == exp_lanes))
  else
  begin
    value_errs++;
    $display("** Error out_lanes: expected %h, actual %h",
             $sampled(exp_lanes), $sampled(out_lanes));
  end

  out_hold_check: assert property (@(posedge clk) disable iff (rst)
    (seen_complete && !complete) |-> (out_lanes == last_out))
  else
  begin
    value_errs++;
    $display("** Error out_lanes: expected %h, actual %h",
             $sampled(last_out), $sampled(out_lanes));
  end

  reset_valid_check: assert property (@(posedge clk) disable iff (rst)
    !seen_complete |-> (out_lanes.valid == '0))
  else
  begin
    value_errs++;
    $display("** Error out_lanes.valid: expected %h, actual %h",
             8'h00, $sampled(out_lanes.valid));
  end

  pulse_check: assert property (@(posedge clk) disable iff (rst)
    complete |=> (!complete && !processing))
  else
  begin
    proto_errs++;
    $display("complete lasted more than one cycle or processing stayed high after it");
  end

  busy_check: assert property (@(posedge clk) disable iff (rst) complete |-> processing)
  else
  begin
    proto_errs++;
    $display("complete was pulsed while processing was low");
  end

  start_check: assert property (@(posedge clk) disable iff (rst)
    (cfg_valid && !processing) |=> processing)
  else
  begin
    proto_errs++;
    $display("processing did not rise one cycle after an accepted strobe");
  end

  run_hold_check: assert property (@(posedge clk) disable iff (rst)
    (processing && !complete) |=> processing)
  else
  begin
    proto_errs++;
    $display("processing fell before complete was pulsed");
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial
  begin
    simd_pkg::lane_set_t lanes;
    simd_pkg::simd_cfg_t c;
    cfg_valid      = 1'b0;
    cfg            = '0;
    in_lanes       = '0;
    exp_lanes      = '0;
    last_out       = '0;
    seen_complete  = 1'b0;
    seed           = 32'hdb3b;
    accepted       = 0;
    complete_count = 0;
    value_errs     = 0;
    proto_errs     = 0;
    @(negedge clk);
    while (rst)
      @(negedge clk);
    assert (!processing && !complete)
    else
    begin
      proto_errs++;
      $display("processing or complete was high right after reset");
    end
    repeat (2) @(negedge clk);

    random_lanes(lanes);  // all NOP
    run_program(make_cfg(simd_pkg::NOP, simd_pkg::NOP, simd_pkg::NOP, simd_pkg::NOP, 3'd0),
                lanes, 1'b0);

    random_lanes(lanes);  // wrapping sum into an invalid target lane
    lanes.valid   = 8'b0101_1011;
    lanes.data[0] = 32'h7fff_ffff;
    lanes.data[1] = 32'h0000_0001;
    run_program(make_cfg(simd_pkg::SUM_SAVE, simd_pkg::NOP, simd_pkg::NOP, simd_pkg::NOP,
                         3'd2), lanes, 1'b0);

    random_lanes(lanes);
    run_program(make_cfg(simd_pkg::RELU, simd_pkg::NOP, simd_pkg::NOP, simd_pkg::NOP, 3'd0),
                lanes, 1'b1);

    random_lanes(lanes);
    run_program(make_cfg(simd_pkg::RELU, simd_pkg::SUM_SAVE, simd_pkg::NOP, simd_pkg::NOP,
                         3'd5), lanes, 1'b0);

    random_lanes(lanes);
    run_program(make_cfg(simd_pkg::SUM_SAVE, simd_pkg::RELU, simd_pkg::SUM_SAVE,
                         simd_pkg::RELU, 3'd7), lanes, 1'b1);

    random_lanes(lanes);  // a middle NOP stops the later RELU stages
    run_program(make_cfg(simd_pkg::SUM_SAVE, simd_pkg::NOP, simd_pkg::RELU, simd_pkg::RELU,
                         3'd1), lanes, 1'b0);

    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      random_lanes(lanes);
      random_cfg(c);
      run_program(c, lanes, n[0]);
    end

    repeat (4) @(negedge clk);
    assert (complete_count == accepted)
    else
    begin
      proto_errs++;
      $display("saw %0d complete pulses for %0d accepted programs", complete_count, accepted);
    end

    $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
    if ((value_errs + proto_errs) == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("run did not finish in %0d ns, a complete pulse never came", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
common/simd_pkg.sv
sfu/sfu_sum.sv
sfu/sfu_relu.sv
rtl/lane_regs.sv
rtl/simd_ctrl.sv
rtl/simd_core.sv
verif/tb_clk_gen.sv
verif/simd_core_tb.sv

/* Bender.yml */
package:
  name: simd_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/simd_pkg.sv
      - sfu/sfu_sum.sv
      - sfu/sfu_relu.sv
      - rtl/lane_regs.sv
      - rtl/simd_ctrl.sv
      - rtl/simd_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/simd_core_tb.sv
